// ==== run_sim.sh ====
#!/bin/sh
# Builds the stopwatch testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f vlog.f -o tb_top_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_top_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation run returned status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== verif/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker
    import board_pkg::*;
# (
    parameter tick_period = 20,
              scan_period = 4
)
(
    input                   clk,
    input                   arst_n,
    input  [3:0]            led,
    input  [7:0]            seg_data,
    input  [n_digits - 1:0] seg_sel,
    input  [17:0]           vga,
    input                   check_req,
    input  [3:0]            check_led,
    input                   check_scan,
    input  int              test_id,
    output logic            check_done,
    output int              pass_count,
    output int              fail_count
);

    localparam logic [3:0] led_idle = 4'b0001;
    localparam logic [3:0] led_run  = 4'b0010;
    localparam logic [3:0] led_lap  = 4'b1000;

    // A scan may start in the middle of a digit.
    localparam int scan_limit = scan_period * (n_digits + 1) + 2;

    localparam int w_time = 4 * n_digits;

    logic [w_time - 1:0] live_m;
    logic [w_time - 1:0] lap_val;
    logic [w_time - 1:0] shown_cur;
    logic [w_time - 1:0] shown_prev;
    logic [w_time - 1:0] disp_val;
    logic                tk;
    logic                tk_cur;
    logic [3:0]          led_prev;
    logic [n_digits - 1:0] seen;
    int                  run_len;
    int                  phase;
    int                  test_errs;
    int                  last_idx;
    int                  scan_len;

    initial begin
        check_done = 1'b0;
        pass_count = 0;
        fail_count = 0;
        phase      = 0;
    end

    function automatic logic [w_time - 1:0] bcd_inc(input logic [w_time - 1:0] t);
        logic [w_time - 1:0] r;
        logic                carry;
        r     = t;
        carry = 1'b1;
        for (int i = 0; i < n_digits; i++) begin
            if (carry) begin
                if (r[4 * i +: 4] == 4'd9) begin
                    r[4 * i +: 4] = 4'd0;
                end else begin
                    r[4 * i +: 4] = r[4 * i +: 4] + 4'd1;
                    carry         = 1'b0;
                end
            end
        end
        return r;
    endfunction

    // Segment a in bit 7 down to the decimal point in bit 0.
    function automatic logic [3:0] seg_to_digit(input logic [7:0] p);
        case (p)
            8'hFC:   return 4'd0;
            8'h60:   return 4'd1;
            8'hDA:   return 4'd2;
            8'hF2:   return 4'd3;
            8'h66:   return 4'd4;
            8'hB6:   return 4'd5;
            8'hBE:   return 4'd6;
            8'hE0:   return 4'd7;
            8'hFE:   return 4'd8;
            8'hF6:   return 4'd9;
            default: return 4'hF;
        endcase
    endfunction

    function automatic int onehot_index(input logic [n_digits - 1:0] sel);
        int idx;
        idx = -1;
        if ($countones(sel) == 1) begin
            for (int i = 0; i < n_digits; i++)
                if (sel[i])
                    idx = i;
        end
        return idx;
    endfunction

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("Test %0d: LED %b display %h PASS", test_id, led, disp_val);
            pass_count++;
        end else begin
            $display("Test %0d: FAIL with %0d errors", test_id, test_errs);
            fail_count++;
        end
        phase = 2;
    endtask

    // Checks one digit of the display against the time of the previous cycle.
    task automatic scan_step();
        int         idx;
        logic [3:0] got;
        logic [3:0] exp;
        idx = onehot_index(~seg_sel);
        scan_len++;
        if (idx < 0) begin
            $display("ERROR at %0t: SEG_SEL expected one-hot select got %b",
                     $time, ~seg_sel);
            test_errs++;
        end else begin
            if (last_idx >= 0 && idx != last_idx && idx != (last_idx + 1) % n_digits) begin
                $display("ERROR at %0t: SEG_SEL expected digit %0d got digit %0d",
                         $time, (last_idx + 1) % n_digits, idx);
                test_errs++;
            end
            last_idx = idx;
            seen[idx] = 1'b1;
            got = seg_to_digit(~seg_data);
            exp = shown_prev[4 * idx +: 4];
            disp_val[4 * idx +: 4] = got;
            if (got !== exp) begin
                $display("ERROR at %0t: SEG_DATA digit %0d expected %h got %h",
                         $time, idx, exp, got);
                test_errs++;
            end
        end
        if (&seen) begin
            finish_test();
        end else if (scan_len > scan_limit) begin
            $display("Display scan did not visit all digits within %0d cycles", scan_limit);
            test_errs++;
            finish_test();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Time model stepped once per cycle.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        shown_prev = shown_cur;
        if (!arst_n) begin
            live_m     = '0;
            lap_val    = '0;
            shown_cur  = '0;
            shown_prev = '0;
            tk         = 1'b0;
            tk_cur     = 1'b0;
            run_len    = 0;
            led_prev   = led_idle;
        end else begin
            // Idle clears the time. A tick lands one cycle after it is made.
            if (led_prev == led_idle)
                live_m = '0;
            else if (tk_cur)
                live_m = bcd_inc(live_m);
            tk_cur = tk;
            if (led == led_run || led == led_lap) begin
                run_len++;
                tk = (run_len == tick_period);
                if (tk)
                    run_len = 0;
            end else begin
                run_len = 0;
                tk      = 1'b0;
            end
            if (led == led_lap && led_prev != led_lap)
                lap_val = live_m;
            shown_cur = (led == led_lap) ? lap_val : live_m;
            led_prev  = led;
        end

        case (phase)
            0: if (check_req) begin
                test_errs = 0;
                disp_val  = '0;
                if (led !== check_led) begin
                    $display("ERROR at %0t: LED expected %b got %b", $time, check_led, led);
                    test_errs++;
                end
                if (vga !== '0) begin
                    $display("ERROR at %0t: VGA_OUT expected %h got %h", $time, 18'h0, vga);
                    test_errs++;
                end
                if (check_scan) begin
                    seen     = '0;
                    last_idx = -1;
                    scan_len = 0;
                    phase    = 1;
                end else begin
                    finish_test();
                end
            end
            1: scan_step();
            default: if (!check_req) phase = 0;
        endcase
        check_done = (phase == 2);
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/10ps

module tb_top
    import board_pkg::*;
;

    localparam int clk_mhz     = 1;
    localparam int tick_hz     = 50000;
    localparam int scan_hz     = 250000;
    localparam int debounce_us = 4;

    localparam logic [1:0] act_wait    = 2'd0;
    localparam logic [1:0] act_press   = 2'd1;
    localparam logic [1:0] act_release = 2'd2;
    localparam logic [1:0] act_bounce  = 2'd3;

    localparam logic [3:0] led_idle   = 4'b0001;
    localparam logic [3:0] led_run    = 4'b0010;
    localparam logic [3:0] led_paused = 4'b0100;
    localparam logic [3:0] led_lap    = 4'b1000;

    // Key 0 start/stop, key 1 clear, key 2 lap.
    typedef struct packed {
        logic [1:0]  act;
        logic [1:0]  key;
        logic [15:0] cycles;
        logic [3:0]  exp_led;
        logic        scan;
    } row_t;

    localparam int n_rows = 25;

    localparam row_t stim_table [n_rows] = '{
        '{act_wait,    2'd0, 16'd10,   led_idle,   1'b1},
        '{act_press,   2'd0, 16'd10,   led_run,    1'b0},
        '{act_release, 2'd0, 16'd500,  led_run,    1'b0},
        '{act_press,   2'd0, 16'd10,   led_paused, 1'b1},
        '{act_release, 2'd0, 16'd40,   led_paused, 1'b1},
        '{act_press,   2'd0, 16'd10,   led_run,    1'b0},
        '{act_release, 2'd0, 16'd1700, led_run,    1'b0},
        '{act_press,   2'd0, 16'd10,   led_paused, 1'b1},
        '{act_release, 2'd0, 16'd10,   led_paused, 1'b0},
        '{act_press,   2'd0, 16'd10,   led_run,    1'b0},
        '{act_release, 2'd0, 16'd200,  led_run,    1'b0},
        '{act_press,   2'd2, 16'd10,   led_lap,    1'b1},
        '{act_release, 2'd2, 16'd300,  led_lap,    1'b1},
        '{act_press,   2'd2, 16'd10,   led_run,    1'b1},
        '{act_release, 2'd2, 16'd100,  led_run,    1'b1},
        '{act_press,   2'd1, 16'd10,   led_run,    1'b0},
        '{act_release, 2'd1, 16'd10,   led_run,    1'b1},
        '{act_bounce,  2'd0, 16'd20,   led_run,    1'b1},
        '{act_bounce,  2'd2, 16'd20,   led_run,    1'b1},
        '{act_press,   2'd0, 16'd10,   led_paused, 1'b0},
        '{act_release, 2'd0, 16'd10,   led_paused, 1'b1},
        '{act_bounce,  2'd1, 16'd20,   led_paused, 1'b1},
        '{act_bounce,  2'd0, 16'd20,   led_paused, 1'b1},
        '{act_press,   2'd1, 16'd10,   led_idle,   1'b1},
        '{act_release, 2'd1, 16'd10,   led_idle,   1'b1}
    };

    logic                  clk = 1'b0;
    logic                  RST_N;
    logic                  KEY2;
    logic                  KEY3;
    logic                  KEY4;
    wire  [3:0]            LED;
    wire  [7:0]            SEG_DATA;
    wire  [n_digits - 1:0] SEG_SEL;
    wire                   VGA_OUT_HS;
    wire                   VGA_OUT_VS;
    wire  [4:0]            VGA_OUT_R;
    wire  [5:0]            VGA_OUT_G;
    wire  [4:0]            VGA_OUT_B;

    logic       check_req;
    logic [3:0] check_led;
    logic       check_scan;
    int         test_id;
    logic       check_done;
    int         pass_count;
    int         fail_count;

    always #5 clk = ~clk;

    board_specific_top
    # (
        .clk_mhz     ( clk_mhz     ),
        .w_key       ( 3           ),
        .w_led       ( 4           ),
        .tick_hz     ( tick_hz     ),
        .scan_hz     ( scan_hz     ),
        .debounce_us ( debounce_us )
    )
    board_specific_top_inst
    (
        .CLK        ( clk        ),
        .RST_N      ( RST_N      ),
        .KEY2       ( KEY2       ),
        .KEY3       ( KEY3       ),
        .KEY4       ( KEY4       ),
        .LED        ( LED        ),
        .SEG_DATA   ( SEG_DATA   ),
        .SEG_SEL    ( SEG_SEL    ),
        .VGA_OUT_HS ( VGA_OUT_HS ),
        .VGA_OUT_VS ( VGA_OUT_VS ),
        .VGA_OUT_R  ( VGA_OUT_R  ),
        .VGA_OUT_G  ( VGA_OUT_G  ),
        .VGA_OUT_B  ( VGA_OUT_B  )
    );

    tb_checker
    # (
        .tick_period ( clk_mhz * 1_000_000 / tick_hz ),
        .scan_period ( clk_mhz * 1_000_000 / scan_hz )
    )
    tb_checker_inst
    (
        .clk        ( clk        ),
        .arst_n     ( RST_N      ),
        .led        ( LED        ),
        .seg_data   ( SEG_DATA   ),
        .seg_sel    ( SEG_SEL    ),
        .vga        ( { VGA_OUT_HS, VGA_OUT_VS, VGA_OUT_R, VGA_OUT_G, VGA_OUT_B } ),
        .check_req  ( check_req  ),
        .check_led  ( check_led  ),
        .check_scan ( check_scan ),
        .test_id    ( test_id    ),
        .check_done ( check_done ),
        .pass_count ( pass_count ),
        .fail_count ( fail_count )
    );

    // Board keys are active low.
    task automatic drive_key(input logic [1:0] k, input logic pressed);
        case (k)
            2'd0:    KEY4 = ~pressed;
            2'd1:    KEY3 = ~pressed;
            default: KEY2 = ~pressed;
        endcase
    endtask

    // Starts and ends on a falling edge.
    task automatic apply_row(input row_t r);
        int glitch_len;
        case (r.act)
            act_press:   drive_key(r.key, 1'b1);
            act_release: drive_key(r.key, 1'b0);
            act_bounce: begin
                glitch_len = int'($urandom % 3) + 1;
                drive_key(r.key, 1'b1);
                repeat (glitch_len) @(negedge clk);
                drive_key(r.key, 1'b0);
            end
            default: ;
        endcase
        repeat (int'(r.cycles)) @(negedge clk);
    endtask

    task automatic request_check(input int id, input row_t r);
        @(posedge clk);
        test_id    = id;
        check_led  = r.exp_led;
        check_scan = r.scan;
        check_req  = 1'b1;
        while (!check_done)
            @(posedge clk);
        check_req = 1'b0;
        @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog sized from the table.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int limit;
        limit = 200 + 3;
        for (int i = 0; i < n_rows; i++)
            limit += int'(stim_table[i].cycles) + 8 + (stim_table[i].scan ? 50 : 0);
        repeat (limit) @(posedge clk);
        $display("Watchdog fired, the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6443_7ff7));
        RST_N      = 1'b0;
        KEY2       = 1'b1;
        KEY3       = 1'b1;
        KEY4       = 1'b1;
        check_req  = 1'b0;
        check_led  = '0;
        check_scan = 1'b0;
        test_id    = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        RST_N = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            apply_row(stim_table[i]);
            request_check(i, stim_table[i]);
        end

        $display("Tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog/bcd_time_counter.sv ====
`timescale 1ns/10ps

module bcd_time_counter
    import board_pkg::*;
    import stopwatch_pkg::*;
(
    input             clk,
    input             arst_n,
    input             tick,
    input             count_clr,
    input             freeze,
    output bcd_time_t shown
);

    bcd_time_t             live;
    bcd_time_t             live_next;
    bcd_time_t             lap_q;
    logic                  freeze_d;
    logic [n_digits - 1:0] carry;

    // Decimal ripple carry. All nines wraps to zero.
    always_comb begin
        carry[0] = tick;
        for (int i = 0; i < n_digits; i++) begin
            if (carry[i])
                live_next[i] = (live[i] == 4'd9) ? 4'd0 : live[i] + 4'd1;
            else
                live_next[i] = live[i];
            if (i < n_digits - 1)
                carry[i + 1] = carry[i] & (live[i] == 4'd9);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live     <= '0;
            freeze_d <= 1'b0;
        end else begin
            live     <= count_clr ? '0 : live_next;
            freeze_d <= freeze;
        end
    end

    // Snapshot on the first frozen cycle.
    always_ff @(posedge clk) begin
        if (freeze && !freeze_d)
            lap_q <= live;
    end

    // The first frozen cycle still shows live, which equals the snapshot.
    assign shown = (freeze && freeze_d) ? lap_q : live;

endmodule

// ==== verilog/board_pkg.sv ====
package board_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Display geometry of the board.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Eight multiplexed digits.
    localparam int n_digits = 8;

    // Width of a digit index.
    localparam int w_digit_idx = $clog2(n_digits);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Segment drive.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit 7 is segment a, bit 0 the decimal point, active high.
    typedef logic [7:0] seg_t;

    localparam seg_t seg_blank = 8'b0000_0000;

    typedef struct packed {
        seg_t                  abcdefgh;
        logic [n_digits - 1:0] digit;
    } seg_drive_t;

endpackage

// ==== verilog/board_specific_top.sv ====
`timescale 1ns/10ps

module board_specific_top
    import board_pkg::*;
# (
    parameter clk_mhz     = 50,
              w_key       = 3,
              w_led       = 4,
              tick_hz     = 100,
              scan_hz     = 1000,
              debounce_us = 10000
)
(
    input                   CLK,
    input                   RST_N,

    input                   KEY2,
    input                   KEY3,
    input                   KEY4,

    output [w_led    - 1:0] LED,

    output [           7:0] SEG_DATA,
    output [n_digits - 1:0] SEG_SEL,

    output                  VGA_OUT_HS,
    output                  VGA_OUT_VS,
    output [           4:0] VGA_OUT_R,
    output [           5:0] VGA_OUT_G,
    output [           4:0] VGA_OUT_B
);

    // Keys are active low on the board.
    wire [w_key - 1:0] key = ~ { KEY2, KEY3, KEY4 };

    seg_drive_t seg;

    top
    # (
        .clk_mhz     ( clk_mhz     ),
        .w_key       ( w_key       ),
        .w_led       ( w_led       ),
        .tick_hz     ( tick_hz     ),
        .scan_hz     ( scan_hz     ),
        .debounce_us ( debounce_us )
    )
    i_top
    (
        .clk    ( CLK   ),
        .arst_n ( RST_N ),
        .key    ( key   ),
        .led    ( LED   ),
        .seg    ( seg   )
    );

    // Display pins sink current.
    assign SEG_DATA   = ~ seg.abcdefgh;
    assign SEG_SEL    = ~ seg.digit;

    // No video on this lab.
    assign VGA_OUT_HS = 1'b0;
    assign VGA_OUT_VS = 1'b0;
    assign VGA_OUT_R  = '0;
    assign VGA_OUT_G  = '0;
    assign VGA_OUT_B  = '0;

endmodule

// ==== verilog/key_conditioner.sv ====
`timescale 1ns/10ps

module key_conditioner
    import stopwatch_pkg::*;
# (
    parameter clk_mhz     = 50,
              w_key       = 3,
              debounce_us = 10000
)
(
    input                clk,
    input                arst_n,
    input  [w_key - 1:0] key,
    output key_cmd_t     cmd
);

    localparam int debounce_cycles = clk_mhz * debounce_us;
    localparam int w_cnt           = $clog2(debounce_cycles + 1);

    logic [w_key - 1:0] key_meta;
    logic [w_key - 1:0] key_sync;
    wire  [w_key - 1:0] press;

    // Two-flop synchronizer.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    for (genvar i = 0; i < w_key; i++) begin : g_key
        logic [w_cnt - 1:0] stable_cnt;
        logic               level;
        logic               level_d;
        logic               pulse;

        // Level follows only after a full run of differing samples.
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                stable_cnt <= '0;
                level      <= 1'b0;
            end else if (key_sync[i] == level) begin
                stable_cnt <= '0;
            end else if (stable_cnt == w_cnt'(debounce_cycles - 1)) begin
                stable_cnt <= '0;
                level      <= key_sync[i];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end

        // Rising edge of the clean level.
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                level_d <= 1'b0;
                pulse   <= 1'b0;
            end else begin
                level_d <= level;
                pulse   <= level & ~level_d;
            end
        end

        assign press[i] = pulse;
    end

    always_comb begin
        cmd.start_stop = press[0];
        cmd.clear      = press[1];
        cmd.lap        = press[2];
    end

endmodule

// ==== verilog/seven_seg_scanner.sv ====
`timescale 1ns/10ps

module seven_seg_scanner
    import board_pkg::*;
    import stopwatch_pkg::*;
(
    input              clk,
    input              arst_n,
    input              scan,
    input  bcd_time_t  shown,
    output seg_drive_t seg
);

    logic [w_digit_idx - 1:0] idx;
    seg_t                     pattern;

    // Segments a to g, decimal point kept off.
    function automatic seg_t bcd_to_seg(input bcd_digit_t d);
        case (d)
            4'd0:    return 8'b1111_1100;
            4'd1:    return 8'b0110_0000;
            4'd2:    return 8'b1101_1010;
            4'd3:    return 8'b1111_0010;
            4'd4:    return 8'b0110_0110;
            4'd5:    return 8'b1011_0110;
            4'd6:    return 8'b1011_1110;
            4'd7:    return 8'b1110_0000;
            4'd8:    return 8'b1111_1110;
            4'd9:    return 8'b1111_0110;
            default: return seg_blank;
        endcase
    endfunction

    // Digit index, wraps after the last digit.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            idx <= '0;
        else if (scan)
            idx <= (idx == w_digit_idx'(n_digits - 1)) ? '0 : idx + 1'b1;
    end

    assign pattern = bcd_to_seg(shown[idx]);

    // Pattern and select leave together, one cycle behind the index.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg.abcdefgh <= bcd_to_seg(4'd0);
            seg.digit    <= n_digits'(1);
        end else begin
            seg.abcdefgh <= pattern;
            seg.digit    <= n_digits'(1) << idx;
        end
    end

endmodule

// ==== verilog/stopwatch_fsm.sv ====
`timescale 1ns/10ps

module stopwatch_fsm
    import stopwatch_pkg::*;
(
    input             clk,
    input             arst_n,
    input  key_cmd_t  cmd,
    output sw_state_t state,
    output logic      count_en,
    output logic      count_clr,
    output logic      freeze
);

    sw_state_t state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= st_idle;
        else
            state <= state_next;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transitions, start/stop wins over the other keys.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_next = state;
        case (state)
            st_idle:
                if (cmd.start_stop) state_next = st_run;
            st_run:
                if (cmd.start_stop)   state_next = st_paused;
                else if (cmd.lap)     state_next = st_lap;
            st_lap:
                if (cmd.start_stop)   state_next = st_paused;
                else if (cmd.lap)     state_next = st_run;
            st_paused:
                if (cmd.start_stop)   state_next = st_run;
                else if (cmd.clear)   state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    // Lap keeps counting behind the frozen display.
    assign count_en  = (state == st_run) || (state == st_lap);
    assign count_clr = (state == st_idle);
    assign freeze    = (state == st_lap);

endmodule

// ==== verilog/stopwatch_pkg.sv ====
package stopwatch_pkg;

    import board_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stopwatch control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Encoding doubles as the LED index.
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_run    = 2'd1,
        st_paused = 2'd2,
        st_lap    = 2'd3
    } sw_state_t;

    // One-cycle command pulses from the keys.
    typedef struct packed {
        logic start_stop;
        logic clear;
        logic lap;
    } key_cmd_t;

    // Digit 0 is the least significant.
    typedef logic [3:0] bcd_digit_t;
    typedef bcd_digit_t [n_digits - 1:0] bcd_time_t;

endpackage

// ==== verilog/tick_timer.sv ====
`timescale 1ns/10ps

module tick_timer
# (
    parameter clk_mhz = 50,
              tick_hz = 100,
              scan_hz = 1000
)
(
    input        clk,
    input        arst_n,
    input        count_en,
    output logic tick,
    output logic scan
);

    localparam int tick_cycles = clk_mhz * 1_000_000 / tick_hz;
    localparam int scan_cycles = clk_mhz * 1_000_000 / scan_hz;
    localparam int w_tick      = $clog2(tick_cycles + 1);
    localparam int w_scan      = $clog2(scan_cycles + 1);

    logic [w_tick - 1:0] tick_cnt;
    logic [w_scan - 1:0] scan_cnt;

    // Counting prescaler, reloaded whenever counting stops.
    // A partial period is dropped that way.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= w_tick'(tick_cycles - 1);
            tick     <= 1'b0;
        end else begin
            tick <= count_en & (tick_cnt == '0);
            if (!count_en || tick_cnt == '0)
                tick_cnt <= w_tick'(tick_cycles - 1);
            else
                tick_cnt <= tick_cnt - 1'b1;
        end
    end

    // Scan prescaler, free running.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt <= w_scan'(scan_cycles - 1);
            scan     <= 1'b0;
        end else begin
            scan     <= (scan_cnt == '0);
            scan_cnt <= (scan_cnt == '0) ? w_scan'(scan_cycles - 1) : scan_cnt - 1'b1;
        end
    end

endmodule

// ==== verilog/top.sv ====
`timescale 1ns/10ps

module top
    import board_pkg::*;
    import stopwatch_pkg::*;
# (
    parameter clk_mhz     = 50,
              w_key       = 3,
              w_led       = 4,
              tick_hz     = 100,
              scan_hz     = 1000,
              debounce_us = 10000
)
(
    input                clk,
    input                arst_n,
    input  [w_key - 1:0] key,
    output [w_led - 1:0] led,
    output seg_drive_t   seg
);

    key_cmd_t  cmd;
    sw_state_t state;
    logic      count_en;
    logic      count_clr;
    logic      freeze;
    logic      tick;
    logic      scan;
    bcd_time_t shown;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    key_conditioner
    # (
        .clk_mhz     ( clk_mhz     ),
        .w_key       ( w_key       ),
        .debounce_us ( debounce_us )
    )
    i_key_conditioner
    (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .key    ( key    ),
        .cmd    ( cmd    )
    );

    stopwatch_fsm i_stopwatch_fsm
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cmd       ( cmd       ),
        .state     ( state     ),
        .count_en  ( count_en  ),
        .count_clr ( count_clr ),
        .freeze    ( freeze    )
    );

    // One LED per state.
    assign led = w_led'(1) << state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Time and display path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    tick_timer
    # (
        .clk_mhz ( clk_mhz ),
        .tick_hz ( tick_hz ),
        .scan_hz ( scan_hz )
    )
    i_tick_timer
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .count_en ( count_en ),
        .tick     ( tick     ),
        .scan     ( scan     )
    );

    bcd_time_counter i_bcd_time_counter
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .tick      ( tick      ),
        .count_clr ( count_clr ),
        .freeze    ( freeze    ),
        .shown     ( shown     )
    );

    seven_seg_scanner i_seven_seg_scanner
    (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .scan   ( scan   ),
        .shown  ( shown  ),
        .seg    ( seg    )
    );

endmodule

// ==== vlog.f ====
verilog/board_pkg.sv
verilog/stopwatch_pkg.sv
verilog/key_conditioner.sv
verilog/tick_timer.sv
verilog/stopwatch_fsm.sv
verilog/bcd_time_counter.sv
verilog/seven_seg_scanner.sv
verilog/top.sv
verilog/board_specific_top.sv
verif/tb_checker.sv
verif/tb_top.sv
